//--- verilog/lsu_pkg.sv
/*
  Widths, memory depth and encodings shared by the LSU subsystem.
  Only word loads and stores exist. Codes 2 and 3 of lsu_op_e are illegal.
*/

package lsu_pkg;

  //--------------------------------------------------------------------
  // Widths
  //--------------------------------------------------------------------

  localparam int DATA_BITS = 32;     // Operands, addresses, data words
  localparam int SEQ_BITS  = 6;      // Reorder sequence number
  localparam int PREG_BITS = 6;      // Physical register tag
  localparam int AREG_BITS = 5;      // Architectural register index

  // Word index taken from byte address bits [9:2]
  localparam int MEM_INDEX_BITS = 8;
  localparam int MEM_WORDS      = 1 << MEM_INDEX_BITS;

  //--------------------------------------------------------------------
  // Encodings
  //--------------------------------------------------------------------

  // Memory micro-op from issue, wide enough to carry an illegal code
  typedef enum logic [1:0] {
    OP_LW = 2'd0,
    OP_SW = 2'd1
  } lsu_op_e;

  // Request kind seen by the data memory
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

endpackage

//--- verilog/lsu_request_stage.sv
/*
  Stage 1 of the LSU. Holds one micro-op and issues its memory request.
  The request only goes out when stage 2 has a free slot for the metadata.
*/

module lsu_request_stage import lsu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 d_val,
  input  logic [DATA_BITS-1:0] d_pc,
  input  logic  [SEQ_BITS-1:0] d_seq_num,
  input  logic [DATA_BITS-1:0] d_op1,
  input  logic [DATA_BITS-1:0] d_op2,
  input  logic [DATA_BITS-1:0] d_store_data,
  input  logic [AREG_BITS-1:0] d_waddr,
  input  logic [PREG_BITS-1:0] d_preg,
  input  logic [PREG_BITS-1:0] d_ppreg,
  input  lsu_op_e              d_uop,
  input  logic                 req_rdy,
  input  logic                 stage2_rdy,
  output logic                 d_rdy,
  output logic                 req_val,
  output mem_op_e              req_op,
  output logic [DATA_BITS-1:0] req_addr,
  output logic [DATA_BITS-1:0] req_data,
  output logic [DATA_BITS-1:0] s1_pc,
  output logic  [SEQ_BITS-1:0] s1_seq_num,
  output logic [AREG_BITS-1:0] s1_waddr,
  output logic [PREG_BITS-1:0] s1_preg,
  output logic [PREG_BITS-1:0] s1_ppreg,
  output logic                 s1_wen
);

  logic                 s1_val;   // Stage holds a micro-op
  logic [DATA_BITS-1:0] s1_op1;
  logic [DATA_BITS-1:0] s1_op2;
  logic [DATA_BITS-1:0] s1_data;  // Store data
  lsu_op_e              s1_uop;
  logic                 d_xfer;
  logic                 req_xfer;

  assign d_xfer   = d_val & d_rdy;
  assign req_xfer = req_val & req_rdy;

  //--------------------------------------------------------------------
  // Micro-op register
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst)
      s1_val <= 1'b0;
    else if (d_xfer)
      s1_val <= 1'b1;       // Refill wins over drain in the same cycle
    else if (req_xfer)
      s1_val <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (d_xfer) begin
      s1_pc      <= d_pc;
      s1_seq_num <= d_seq_num;
      s1_op1     <= d_op1;
      s1_op2     <= d_op2;
      s1_data    <= d_store_data;
      s1_waddr   <= d_waddr;
      s1_preg    <= d_preg;
      s1_ppreg   <= d_ppreg;
      s1_uop     <= d_uop;
    end
  end

  //--------------------------------------------------------------------
  // Memory request
  //--------------------------------------------------------------------

  always_comb begin
    case (s1_uop)
      OP_LW:   req_op = MEM_READ;
      OP_SW:   req_op = MEM_WRITE;
      default: req_op = MEM_READ;   // Illegal code, caught below
    endcase
  end

  assign req_addr = s1_op1 + s1_op2;     // Byte address
  assign req_data = s1_data;
  assign req_val  = s1_val & stage2_rdy; // Metadata needs a slot first
  assign s1_wen   = (s1_uop == OP_LW);   // Only loads write a register
  assign d_rdy    = !s1_val | req_xfer;  // Empty or emptying now

  // Issue side must only ever deliver a load or a store
  a_legal_uop: assert property (@(posedge clk) disable iff (rst)
    s1_val |-> (s1_uop inside {OP_LW, OP_SW}));

endmodule

//--- verilog/lsu_response_stage.sv
/*
  Stage 2 of the LSU. Holds the metadata of the one request in flight and
  joins it with the memory response toward writeback in the same cycle.
*/

module lsu_response_stage import lsu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_val,
  input  logic                 req_rdy,
  input  logic [DATA_BITS-1:0] s1_pc,
  input  logic  [SEQ_BITS-1:0] s1_seq_num,
  input  logic [AREG_BITS-1:0] s1_waddr,
  input  logic [PREG_BITS-1:0] s1_preg,
  input  logic [PREG_BITS-1:0] s1_ppreg,
  input  logic                 s1_wen,
  input  logic                 resp_val,
  input  logic [DATA_BITS-1:0] resp_data,
  input  logic                 w_rdy,
  output logic                 stage2_rdy,
  output logic                 resp_rdy,
  output logic                 w_val,
  output logic [DATA_BITS-1:0] w_pc,
  output logic  [SEQ_BITS-1:0] w_seq_num,
  output logic [AREG_BITS-1:0] w_waddr,
  output logic [PREG_BITS-1:0] w_preg,
  output logic [PREG_BITS-1:0] w_ppreg,
  output logic                 w_wen,
  output logic [DATA_BITS-1:0] w_wdata
);

  logic s2_val;     // A request is in flight
  logic req_xfer;
  logic w_xfer;

  assign req_xfer = req_val & req_rdy;
  assign w_xfer   = w_val & w_rdy;

  always_ff @(posedge clk) begin
    if (rst)
      s2_val <= 1'b0;
    else if (req_xfer)
      s2_val <= 1'b1;
    else if (w_xfer)
      s2_val <= 1'b0;
  end

  // Metadata of the accepted request, read out directly as writeback
  always_ff @(posedge clk) begin
    if (req_xfer) begin
      w_pc      <= s1_pc;
      w_seq_num <= s1_seq_num;
      w_waddr   <= s1_waddr;
      w_preg    <= s1_preg;
      w_ppreg   <= s1_ppreg;
      w_wen     <= s1_wen;
    end
  end

  //--------------------------------------------------------------------
  // Response join
  //--------------------------------------------------------------------

  assign w_val      = s2_val & resp_val;
  assign resp_rdy   = s2_val & w_rdy;
  assign w_wdata    = resp_data;         // Zero for stores
  assign stage2_rdy = !s2_val | w_xfer;  // Free now or drained this cycle

  // Memory never answers a request whose metadata is not held here
  a_resp_has_meta: assert property (@(posedge clk) disable iff (rst)
    resp_val |-> s2_val);

endmodule

//--- verilog/data_memory.sv
/*
  256-word data memory with a single registered response slot.
  Byte address bits above [9:2] are ignored and accesses must be aligned.
  Contents are not cleared by reset.
*/

module data_memory import lsu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_val,
  input  mem_op_e              req_op,
  input  logic [DATA_BITS-1:0] req_addr,
  input  logic [DATA_BITS-1:0] req_data,
  input  logic                 resp_rdy,
  output logic                 req_rdy,
  output logic                 resp_val,
  output logic [DATA_BITS-1:0] resp_data
);

  logic [DATA_BITS-1:0]      mem [MEM_WORDS];
  logic [MEM_INDEX_BITS-1:0] index;
  logic                      req_xfer;
  logic                      resp_xfer;

  assign index     = req_addr[MEM_INDEX_BITS+1:2];  // Word index
  assign req_xfer  = req_val & req_rdy;
  assign resp_xfer = resp_val & resp_rdy;

  // Accept when the response slot is empty or leaves this cycle
  assign req_rdy = !resp_val | resp_rdy;

  //--------------------------------------------------------------------
  // Response slot
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst)
      resp_val <= 1'b0;
    else if (req_xfer)
      resp_val <= 1'b1;
    else if (resp_xfer)
      resp_val <= 1'b0;
  end

  //--------------------------------------------------------------------
  // Array access at acceptance
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_xfer) begin
      if (req_op == MEM_WRITE) begin
        mem[index] <= req_data;
        resp_data  <= '0;          // Write ack carries no data
      end else begin
        resp_data  <= mem[index];  // Sees all earlier writes
      end
    end
  end

  // Address comes from the operand sum in stage 1
  a_word_aligned: assert property (@(posedge clk) disable iff (rst)
    req_xfer |-> (req_addr[1:0] == 2'b00));

endmodule

//--- verilog/lsu_top.sv
/*
  LSU subsystem top. Two cycles from issue to writeback with one micro-op
  per cycle when writeback is ready. A writeback stall backs up to d_rdy.
*/

module lsu_top import lsu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  // Issue
  input  logic                 d_val,
  input  logic [DATA_BITS-1:0] d_pc,
  input  logic  [SEQ_BITS-1:0] d_seq_num,
  input  logic [DATA_BITS-1:0] d_op1,
  input  logic [DATA_BITS-1:0] d_op2,
  input  logic [DATA_BITS-1:0] d_store_data,
  input  logic [AREG_BITS-1:0] d_waddr,
  input  logic [PREG_BITS-1:0] d_preg,
  input  logic [PREG_BITS-1:0] d_ppreg,
  input  lsu_op_e              d_uop,
  output logic                 d_rdy,
  // Writeback
  output logic                 w_val,
  output logic [DATA_BITS-1:0] w_pc,
  output logic  [SEQ_BITS-1:0] w_seq_num,
  output logic [AREG_BITS-1:0] w_waddr,
  output logic [PREG_BITS-1:0] w_preg,
  output logic [PREG_BITS-1:0] w_ppreg,
  output logic                 w_wen,
  output logic [DATA_BITS-1:0] w_wdata,
  input  logic                 w_rdy
);

  //--------------------------------------------------------------------
  // Internal links
  //--------------------------------------------------------------------

  logic                 req_val, req_rdy;         // Stage 1 to memory
  mem_op_e              req_op;
  logic [DATA_BITS-1:0] req_addr, req_data;
  logic                 resp_val, resp_rdy;       // Memory to stage 2
  logic [DATA_BITS-1:0] resp_data;
  logic                 stage2_rdy;               // Slot free in stage 2
  logic [DATA_BITS-1:0] s1_pc;                    // Metadata handoff
  logic  [SEQ_BITS-1:0] s1_seq_num;
  logic [AREG_BITS-1:0] s1_waddr;
  logic [PREG_BITS-1:0] s1_preg, s1_ppreg;
  logic                 s1_wen;

  lsu_request_stage i_request (
    .clk, .rst,
    .d_val, .d_pc, .d_seq_num, .d_op1, .d_op2, .d_store_data,
    .d_waddr, .d_preg, .d_ppreg, .d_uop, .d_rdy,
    .req_val, .req_op, .req_addr, .req_data, .req_rdy,
    .stage2_rdy,
    .s1_pc, .s1_seq_num, .s1_waddr, .s1_preg, .s1_ppreg, .s1_wen
  );

  data_memory i_memory (
    .clk, .rst,
    .req_val, .req_op, .req_addr, .req_data, .req_rdy,
    .resp_val, .resp_data, .resp_rdy
  );

  lsu_response_stage i_response (
    .clk, .rst,
    .req_val, .req_rdy,
    .s1_pc, .s1_seq_num, .s1_waddr, .s1_preg, .s1_ppreg, .s1_wen,
    .resp_val, .resp_data, .resp_rdy,
    .stage2_rdy,
    .w_val, .w_pc, .w_seq_num, .w_waddr, .w_preg, .w_ppreg, .w_wen,
    .w_wdata, .w_rdy
  );

endmodule

//--- testbench/lsu_tb.sv
/*
  Testbench for lsu_top. Random word loads and stores inside a 16-word window
  at byte 0x100, checked against a memory model and an expected writeback queue.
  Stimulus seeded once, so every run is repeatable.
*/

module lsu_tb import lsu_pkg::*; ;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES   = 8;
  localparam int TOTAL_OPS      = 16 + 32 + 32 + 400 + 200;  // All tests together
  localparam int TIMEOUT_CYCLES = TOTAL_OPS * 20 + RESET_CYCLES;
  localparam int DRAIN_LIMIT    = 64;                      // Cycles to empty the pipe
  localparam logic [31:0] WIN_BASE = 32'h0000_0100;        // Word index 64

  typedef struct packed {
    logic [DATA_BITS-1:0] pc;
    logic [SEQ_BITS-1:0]  seq;
    logic [AREG_BITS-1:0] waddr;
    logic [PREG_BITS-1:0] preg;
    logic [PREG_BITS-1:0] ppreg;
    logic                 wen;
    logic [DATA_BITS-1:0] data;
    logic [31:0]          cycle;  // Cycle count when issue was seen
  } wb_t;

  logic clk, rst;
  logic d_val, d_rdy, w_val, w_rdy, w_wen;
  logic [DATA_BITS-1:0] d_pc, d_op1, d_op2, d_store_data, w_pc, w_wdata;
  logic [SEQ_BITS-1:0]  d_seq_num, w_seq_num;
  logic [AREG_BITS-1:0] d_waddr, w_waddr;
  logic [PREG_BITS-1:0] d_preg, d_ppreg, w_preg, w_ppreg;
  lsu_op_e              d_uop;

  logic [DATA_BITS-1:0] model [MEM_WORDS];  // Expected memory contents
  wb_t  exp_q[$];                            // Expected writebacks, in order
  int   cycle = 0;
  int   errors = 0, checks = 0, issue_count = 0, wb_count = 0;
  bit   stream_mode = 0;   // w_rdy high, latency must be exactly 2
  bit   bp_mode = 0;       // Random w_rdy
  logic [SEQ_BITS-1:0] next_seq = '0;

  lsu_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // Cycle count and watchdog
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  // Writeback ready, random only under back-pressure
  initial begin
    w_rdy = 1'b1;
    forever begin
      @(posedge clk);
      #1 w_rdy = bp_mode ? 1'($urandom % 2) : 1'b1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  //--------------------------------------------------------------------
  // Monitor and scoreboard, sampled mid-cycle where all is settled
  //--------------------------------------------------------------------

  always @(negedge clk) begin
    wb_t e;
    logic [DATA_BITS-1:0] sum;
    if (!rst) begin
      if (w_val && w_rdy) begin  // Writeback leaves at next edge
        wb_count++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Writeback of seq %0d arrived with nothing outstanding", w_seq_num);
        end else begin
          e = exp_q.pop_front();
          check_value("w_pc", w_pc, e.pc);
          check_value("w_seq_num", 32'(w_seq_num), 32'(e.seq));
          check_value("w_waddr", 32'(w_waddr), 32'(e.waddr));
          check_value("w_preg", 32'(w_preg), 32'(e.preg));
          check_value("w_ppreg", 32'(w_ppreg), 32'(e.ppreg));
          check_value("w_wen", 32'(w_wen), 32'(e.wen));
          check_value("w_wdata", w_wdata, e.data);
          if (stream_mode)
            check_value("latency", 32'(cycle) - e.cycle, 32'd2);
        end
      end
      if (d_val && d_rdy) begin  // Issue transfer at next edge
        sum     = d_op1 + d_op2;  // Model forms its own address
        e.pc    = d_pc;
        e.seq   = d_seq_num;
        e.waddr = d_waddr;
        e.preg  = d_preg;
        e.ppreg = d_ppreg;
        e.cycle = 32'(cycle);
        if (d_uop == OP_SW) begin
          model[sum[MEM_INDEX_BITS+1:2]] = d_store_data;
          e.wen  = 1'b0;
          e.data = '0;           // Store ack
        end else begin
          e.wen  = 1'b1;
          e.data = model[sum[MEM_INDEX_BITS+1:2]];
        end
        exp_q.push_back(e);
        issue_count++;
      end
      if (stream_mode && d_val)
        check_value("d_rdy", 32'(d_rdy), 32'd1);  // No stall in streaming
    end
  end

  //--------------------------------------------------------------------
  // Stimulus helpers, called at 1 ns after a rising edge
  //--------------------------------------------------------------------

  // Word below zero picks a random word of the window
  task automatic send_op(input bit force_store, input bit random_gap, input int word);
    logic [31:0] r, r2;
    logic [DATA_BITS-1:0] addr;
    bit accepted;
    while (random_gap && ($urandom % 3 == 0)) begin  // Idle cycles
      d_val = 1'b0;
      @(posedge clk);
      #1;
    end
    r    = $urandom;
    r2   = $urandom;
    if (word >= 0)
      r[3:0] = 4'(word);
    addr = WIN_BASE + {26'd0, r[3:0], 2'b00};  // One of 16 words
    d_op1        = $urandom;
    d_op2        = addr - d_op1;               // Aligned sum by construction
    d_uop        = (force_store || r[4]) ? OP_SW : OP_LW;
    d_store_data = $urandom;
    d_pc         = {r2[31:2], 2'b00};
    d_seq_num    = next_seq;
    d_waddr      = r[9:5];
    d_preg       = r[15:10];
    d_ppreg      = r[21:16];
    d_val        = 1'b1;
    next_seq     = next_seq + 1'b1;
    do begin
      @(negedge clk);
      accepted = d_rdy;
      @(posedge clk);
      #1;
    end while (!accepted);
  endtask

  task automatic drain_pipe();
    int waited;
    d_val = 1'b0;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    repeat (3) @(posedge clk);  // Room for a stray duplicate to show
    #1;
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    $display("Test %0d %s finished with %0d errors", num, name, errors - err_before);
  endtask

  //--------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------

  initial begin
    int err_before;
    void'($urandom(96205));
    rst = 1'b1;
    d_val = 1'b0;
    d_pc = '0;
    d_seq_num = '0;
    d_op1 = '0;
    d_op2 = '0;
    d_store_data = '0;
    d_waddr = '0;
    d_preg = '0;
    d_ppreg = '0;
    d_uop = OP_LW;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;

    err_before = errors;  // 1: idle state after reset
    @(negedge clk);
    check_value("d_rdy", 32'(d_rdy), 32'd1);
    check_value("w_val", 32'(w_val), 32'd0);
    @(posedge clk);
    #1;
    report_test(1, "reset_state", err_before);

    err_before = errors;  // 2: warm-up stores then back-to-back stream
    stream_mode = 1;
    for (int i = 0; i < 16; i++) begin
      d_val = 1'b1;
      send_op(1'b1, 1'b0, i);  // One store to each word of the window
    end
    for (int i = 0; i < 32; i++)
      send_op(1'b0, 1'b0, -1);
    drain_pipe();
    report_test(2, "streaming", err_before);

    err_before = errors;  // 3: metadata with issue gaps
    for (int i = 0; i < 32; i++)
      send_op(1'b0, 1'b1, -1);
    drain_pipe();
    report_test(3, "metadata", err_before);

    err_before = errors;  // 4: read after write
    for (int i = 0; i < 400; i++)
      send_op(1'b0, 1'b0, -1);
    drain_pipe();
    report_test(4, "read_after_write", err_before);

    err_before = errors;  // 5: random stalls on both ends
    stream_mode = 0;
    bp_mode = 1;
    for (int i = 0; i < 200; i++)
      send_op(1'b0, 1'b1, -1);
    drain_pipe();
    bp_mode = 0;
    check_value("wb_count", 32'(wb_count), 32'(issue_count));
    check_value("queue_size", 32'(exp_q.size()), 32'd0);
    report_test(5, "back_pressure", err_before);

    $display("Checks %0d, errors %0d, issued %0d, written back %0d",
             checks, errors, issue_count, wb_count);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

//--- lsu_subsys.f
verilog/lsu_pkg.sv
verilog/lsu_request_stage.sv
verilog/lsu_response_stage.sv
verilog/data_memory.sv
verilog/lsu_top.sv
testbench/lsu_tb.sv

//--- Makefile
# Verilator flow for the LSU subsystem

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= lsu_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= No errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
